// ==== Bender.yml ====
package:
  name: sdram_subsys

sources:
  - include_dirs:
      - design
    files:
      - design/sdram_pkg.sv
      - design/client_mapper.sv
      - design/bank_slot_arbiter.sv
      - design/sdram_bank_ctrl.sv
      - design/rom_loader.sv
      - design/sdram_subsys_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/sdram_properties.sv
      - verif/tb_sdram_subsys.sv

// ==== design/bank_slot_arbiter.sv ====
// Two slot bank arbiter
// Each slot remembers its last read word and acks repeated reads from it.
// Misses and writes go to the controller one at a time over req/ack.
`timescale 1ns/100ps
`include "sdram_defs.svh"

module bank_slot_arbiter
    import sdram_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             flush,
    input  logic [1:0]       slot_req,
    input  bank_req_t [1:0]  slot_cmd,
    output logic [1:0]       slot_ack,
    output word_t [1:0]      slot_rdata,
    output logic             mem_req,
    output bank_req_t        mem_cmd,
    input  logic             mem_ack,
    input  word_t            mem_rdata
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_REQ,    // mem_req up, waiting for ack
        ARB_DONE    // waiting for mem_ack to fall
    } arb_state_t;

    arb_state_t state;
    logic cur;                  // Slot being served
    logic wait1;                // Slot 1 was passed over
    logic [`BANK_AW-1:0] cache_addr [2];
    word_t [1:0] cache_data;
    logic [1:0] cache_valid;
    logic [1:0] hit;
    logic [1:0] want;
    logic grant1;

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            hit[s] = cache_valid[s] && (cache_addr[s] == slot_cmd[s].addr)
                   && !slot_cmd[s].we;
            want[s] = slot_req[s] && !slot_ack[s] && !hit[s]
                    && !(state != ARB_IDLE && cur == 1'(s));
        end
        grant1 = want[1] && (!want[0] || wait1);
    end

    assign slot_rdata = cache_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ARB_IDLE;
            cur         <= 1'b0;
            wait1       <= 1'b0;
            mem_req     <= 1'b0;
            slot_ack    <= '0;
            cache_valid <= '0;
        end else begin
            for (int s = 0; s < 2; s++) begin
                if (slot_ack[s] && !slot_req[s]) begin
                    slot_ack[s] <= 1'b0;
                end else if (slot_req[s] && !slot_ack[s] && hit[s]) begin
                    slot_ack[s] <= 1'b1;  // Served from the last word
                end
            end
            case (state)
                ARB_IDLE: begin
                    if (|want) begin
                        cur     <= grant1;
                        wait1   <= grant1 ? 1'b0 : want[1];
                        mem_cmd <= slot_cmd[grant1];
                        mem_req <= 1'b1;
                        state   <= ARB_REQ;
                    end
                end
                ARB_REQ: begin
                    if (mem_ack) begin
                        mem_req       <= 1'b0;
                        slot_ack[cur] <= 1'b1;
                        state         <= ARB_DONE;
                        if (mem_cmd.we) begin
                            // Keep the cached word coherent with our own write
                            if (cache_valid[cur] && cache_addr[cur] == mem_cmd.addr) begin
                                cache_data[cur] <= merge_word(cache_data[cur],
                                                              mem_cmd.wdata, mem_cmd.wmask);
                            end
                        end else begin
                            cache_addr[cur]  <= mem_cmd.addr;
                            cache_data[cur]  <= mem_rdata;
                            cache_valid[cur] <= 1'b1;
                        end
                    end
                end
                ARB_DONE: begin
                    if (!mem_ack) state <= ARB_IDLE;
                end
                default: state <= ARB_IDLE;
            endcase
            if (flush) cache_valid <= '0;  // New image in memory
        end
    end

endmodule

// ==== design/client_mapper.sv ====
// Client mapper
// Registers the eight client requests and turns them into per-bank slot requests.
// Graphics clients only get through during blanking, nobody while downloading.
`timescale 1ns/100ps
`include "sdram_defs.svh"

module client_mapper
    import sdram_pkg::*;
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              lvbl,
    input  logic [8:0]                        vrender,
    input  logic                              downloading,
    input  logic [`NCLIENTS-1:0]              cli_req,
    input  client_cmd_t [`NCLIENTS-1:0]       cli_cmd,
    output logic [`NCLIENTS-1:0]              cli_ack,
    output logic [`NBANKS-1:0][1:0]           slot_req,
    output bank_req_t [`NBANKS-1:0][1:0]      slot_cmd,
    input  logic [`NBANKS-1:0][1:0]           slot_ack
);

    logic [`NCLIENTS-1:0] req_q;
    client_cmd_t [`NCLIENTS-1:0] cmd_q;
    logic [`NCLIENTS-1:0] allow;
    logic gfx_ok;

    assign gfx_ok = ~lvbl | (vrender == 9'd0) | vrender[8];  // Blanking

    always_comb begin
        for (int c = 0; c < `NCLIENTS; c++) begin
            allow[c] = (c < CLI_CHAR) | gfx_ok;
        end
    end

    // Once accepted a request stays up until the client drops it
    always_ff @(posedge clk) begin
        if (reset) begin
            req_q <= '0;
        end else begin
            req_q <= cli_req & ~{`NCLIENTS{downloading}} & (req_q | allow);
        end
    end

    always_ff @(posedge clk) begin
        for (int c = 0; c < `NCLIENTS; c++) begin
            if (!req_q[c]) cmd_q[c] <= cli_cmd[c];  // Frozen during the handshake
        end
    end

    always_comb begin
        for (int c = 0; c < `NCLIENTS; c++) begin
            slot_req[c/2][c%2] = req_q[c] & cli_req[c];  // Release is seen at once
            slot_cmd[c/2][c%2].addr = {1'b0, cmd_q[c].addr}
                                    + ((c % 2 == 1) ? `BANK_AW'(`SLOT1_OFFSET) : '0);
            if (c == CLI_MAIN_RAM) begin
                slot_cmd[c/2][c%2].we    = cmd_q[c].we;
                slot_cmd[c/2][c%2].wdata = cmd_q[c].wdata;
                slot_cmd[c/2][c%2].wmask = cmd_q[c].wmask;
            end else begin
                // Read only client
                slot_cmd[c/2][c%2].we    = 1'b0;
                slot_cmd[c/2][c%2].wdata = '0;
                slot_cmd[c/2][c%2].wmask = '0;
            end
            cli_ack[c] = slot_ack[c/2][c%2] & ~downloading;
        end
    end

endmodule

// ==== design/rom_loader.sv ====
// ROM download loader
// Latches the game id and decryption flags from the header, then packs
// the byte stream into words and writes them to memory.
`timescale 1ns/100ps
`include "sdram_defs.svh"

module rom_loader
    import sdram_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               downloading,
    input  logic               ioctl_req,
    input  logic [15:0]        ioctl_addr,
    input  logic [7:0]         ioctl_data,
    output logic               ioctl_ack,
    output logic               prog_req,
    output logic [`MEM_AW-1:0] prog_addr,
    output word_t              prog_data,
    output logic [1:0]         prog_mask,
    input  logic               prog_ack,
    output logic [1:0]         game_id,
    output logic [2:0]         dec_flags,
    output logic               dwnld_busy
);

    logic [15:0] rel_addr;
    logic is_header;
    logic start;
    logic [7:0] low_byte;

    assign rel_addr   = ioctl_addr - 16'(`HEADER_LEN);
    assign is_header  = ioctl_addr < 16'(`HEADER_LEN);
    assign start      = downloading && ioctl_req && !ioctl_ack && !prog_req && !prog_ack;
    assign dwnld_busy = downloading | prog_req;
    assign prog_mask  = 2'b00;  // Both byte lanes

    always_ff @(posedge clk) begin
        if (reset) begin
            ioctl_ack <= 1'b0;
            prog_req  <= 1'b0;
            game_id   <= '0;
            dec_flags <= '0;
        end else begin
            if (ioctl_ack && !ioctl_req) ioctl_ack <= 1'b0;
            if (prog_req && prog_ack) begin
                prog_req  <= 1'b0;
                ioctl_ack <= 1'b1;  // Odd byte released once the word is stored
            end
            if (start) begin
                if (is_header) begin
                    if (ioctl_addr == 16'd0) dec_flags <= ioctl_data[2:0];
                    if (ioctl_addr == 16'd1) game_id <= ioctl_data[1:0];
                    ioctl_ack <= 1'b1;
                end else if (rel_addr[0]) begin
                    prog_req <= 1'b1;
                end else begin
                    ioctl_ack <= 1'b1;
                end
            end
        end
    end

    // Low byte first
    always_ff @(posedge clk) begin
        if (start && !is_header) begin
            if (!rel_addr[0]) begin
                low_byte <= ioctl_data;
            end else begin
                prog_addr <= rel_addr[`MEM_AW:1];
                prog_data <= {ioctl_data, low_byte};
            end
        end
    end

endmodule

// ==== design/sdram_bank_ctrl.sv ====
// SDRAM bank controller model
// Serves the loader and four banks round robin on one word array.
// Reads return through a three stage delay line, writes finish in one cycle.
`timescale 1ns/100ps
`include "sdram_defs.svh"

module sdram_bank_ctrl
    import sdram_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`NBANKS-1:0]         mem_req,
    input  bank_req_t [`NBANKS-1:0]    mem_cmd,
    output logic [`NBANKS-1:0]         mem_ack,
    output word_t [`NBANKS-1:0]        mem_rdata,
    input  logic                       prog_req,
    input  logic [`MEM_AW-1:0]         prog_addr,
    input  word_t                      prog_data,
    input  logic [1:0]                 prog_mask,
    output logic                       prog_ack
);

    localparam int NREQ = `NBANKS + 1;       // Loader is requester 0
    localparam int BSEL = `MEM_AW - `BANK_AW;

    word_t mem [2**`MEM_AW];
    logic [NREQ-1:0] req_all, busy, elig, ack;
    logic [`MEM_AW-1:0] op_addr [NREQ];
    logic [NREQ-1:0] op_we;
    word_t op_data [NREQ];
    logic [1:0] op_mask [NREQ];
    logic [2:0] last, pick;
    logic pick_valid;
    logic [2:0] pv;                           // Delay line valid bits
    logic [2:0] s0_idx, s1_idx, s2_idx;
    logic [`MEM_AW-1:0] s0_addr, s1_addr, s2_addr;
    logic s0_we;
    word_t s0_data;
    logic [1:0] s0_mask;
    word_t rd_word;

    always_comb begin
        req_all[0] = prog_req;
        op_addr[0] = prog_addr;
        op_we[0]   = 1'b1;
        op_data[0] = prog_data;
        op_mask[0] = prog_mask;
        for (int b = 0; b < `NBANKS; b++) begin
            req_all[b+1] = mem_req[b];
            op_addr[b+1] = {BSEL'(b), mem_cmd[b].addr};  // Bank picks the top bits
            op_we[b+1]   = mem_cmd[b].we;
            op_data[b+1] = mem_cmd[b].wdata;
            op_mask[b+1] = mem_cmd[b].wmask;
        end
    end

    assign elig = req_all & ~busy;

    // Next eligible requester after the last one granted
    always_comb begin
        int idx;
        pick       = last;
        pick_valid = 1'b0;
        for (int i = 1; i <= NREQ; i++) begin
            idx = (int'(last) + i) % NREQ;
            if (!pick_valid && elig[idx]) begin
                pick       = 3'(idx);
                pick_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
            ack  <= '0;
            last <= '0;
            pv   <= '0;
        end else begin
            pv <= {pv[1], pv[0] & ~s0_we, pick_valid};  // Writes leave after stage 0
            if (pick_valid) begin
                busy[pick] <= 1'b1;
                last       <= pick;
            end
            for (int r = 0; r < NREQ; r++) begin
                if (ack[r] && !req_all[r]) begin
                    ack[r]  <= 1'b0;
                    busy[r] <= 1'b0;
                end
            end
            if (pv[0] && s0_we) ack[s0_idx] <= 1'b1;
            if (pv[2]) ack[s2_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        s0_idx  <= pick;
        s0_addr <= op_addr[pick];
        s0_we   <= op_we[pick];
        s0_data <= op_data[pick];
        s0_mask <= op_mask[pick];
        s1_idx  <= s0_idx;
        s1_addr <= s0_addr;
        s2_idx  <= s1_idx;
        s2_addr <= s1_addr;
        if (pv[0] && s0_we) mem[s0_addr] <= merge_word(mem[s0_addr], s0_data, s0_mask);
        if (pv[2]) rd_word <= mem[s2_addr];
    end

    assign prog_ack  = ack[0];
    assign mem_ack   = ack[NREQ-1:1];
    assign mem_rdata = {`NBANKS{rd_word}};  // Valid for the bank being acked

endmodule

// ==== design/sdram_defs.svh ====
// SDRAM front end sizing
// Address widths, bank and client counts, slot offset and download header length
`ifndef SDRAM_DEFS_SVH
`define SDRAM_DEFS_SVH

// Whole array is 4K words, split into four banks
`define MEM_AW        12
`define BANK_AW       10

`define NBANKS        4
`define NCLIENTS      8   // Two slots per bank

// Slot 1 lives in the upper half of every bank
`define SLOT1_OFFSET  512

// Download header bytes ahead of the ROM image
`define HEADER_LEN    16

`endif

// ==== design/sdram_pkg.sv ====
// SDRAM front end types
// Client command, bank request, data word and client numbering
`include "sdram_defs.svh"

package sdram_pkg;

    typedef logic [15:0] word_t;

    // Slot relative command from a game client
    typedef struct packed {
        logic [`BANK_AW-2:0] addr;
        logic                we;
        word_t               wdata;
        logic [1:0]          wmask;   // Active low per byte
    } client_cmd_t;

    // Arbiter to controller request, bank address
    typedef struct packed {
        logic [`BANK_AW-1:0] addr;
        logic                we;
        word_t               wdata;
        logic [1:0]          wmask;
    } bank_req_t;

    localparam int CLI_MAIN_RAM = 0;
    localparam int CLI_MAIN_ROM = 1;
    localparam int CLI_SOUND    = 2;
    localparam int CLI_ADPCM    = 3;
    localparam int CLI_CHAR     = 4;  // First graphics client
    localparam int CLI_SCROLL   = 5;
    localparam int CLI_OBJECT   = 6;
    localparam int CLI_ROAD     = 7;

    // Byte lane merge, a low mask bit takes the new byte
    function automatic word_t merge_word(word_t old_w, word_t new_w, logic [1:0] mask);
        word_t res;
        res[7:0]  = mask[0] ? old_w[7:0]  : new_w[7:0];
        res[15:8] = mask[1] ? old_w[15:8] : new_w[15:8];
        return res;
    endfunction

endpackage

// ==== design/sdram_subsys_top.sv ====
// SDRAM memory front end
// Client mapper, one slot arbiter per bank, the bank controller and the loader
`timescale 1ns/100ps
`include "sdram_defs.svh"

module sdram_subsys_top
    import sdram_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         lvbl,
    input  logic [8:0]                   vrender,
    input  logic                         downloading,
    input  logic                         ioctl_req,
    input  logic [15:0]                  ioctl_addr,
    input  logic [7:0]                   ioctl_data,
    output logic                         ioctl_ack,
    output logic                         dwnld_busy,
    output logic [1:0]                   game_id,
    output logic [2:0]                   dec_flags,
    input  logic [`NCLIENTS-1:0]         cli_req,
    input  client_cmd_t [`NCLIENTS-1:0]  cli_cmd,
    output logic [`NCLIENTS-1:0]         cli_ack,
    output word_t [`NCLIENTS-1:0]        cli_rdata
);

    logic [`NBANKS-1:0][1:0] slot_req, slot_ack;
    bank_req_t [`NBANKS-1:0][1:0] slot_cmd;
    logic [`NBANKS-1:0] mem_req, mem_ack;
    bank_req_t [`NBANKS-1:0] mem_cmd;
    word_t [`NBANKS-1:0] mem_rdata;
    logic prog_req, prog_ack;
    logic [`MEM_AW-1:0] prog_addr;
    word_t prog_data;
    logic [1:0] prog_mask;

    client_mapper u_mapper (
        .clk        (clk),
        .reset      (reset),
        .lvbl       (lvbl),
        .vrender    (vrender),
        .downloading(downloading),
        .cli_req    (cli_req),
        .cli_cmd    (cli_cmd),
        .cli_ack    (cli_ack),
        .slot_req   (slot_req),
        .slot_cmd   (slot_cmd),
        .slot_ack   (slot_ack)
    );

    for (genvar b = 0; b < `NBANKS; b++) begin : g_bank
        bank_slot_arbiter u_arb (
            .clk       (clk),
            .reset     (reset),
            .flush     (downloading),
            .slot_req  (slot_req[b]),
            .slot_cmd  (slot_cmd[b]),
            .slot_ack  (slot_ack[b]),
            .slot_rdata(cli_rdata[2*b+1:2*b]),
            .mem_req   (mem_req[b]),
            .mem_cmd   (mem_cmd[b]),
            .mem_ack   (mem_ack[b]),
            .mem_rdata (mem_rdata[b])
        );
    end

    sdram_bank_ctrl u_ctrl (
        .clk      (clk),
        .reset    (reset),
        .mem_req  (mem_req),
        .mem_cmd  (mem_cmd),
        .mem_ack  (mem_ack),
        .mem_rdata(mem_rdata),
        .prog_req (prog_req),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .prog_mask(prog_mask),
        .prog_ack (prog_ack)
    );

    rom_loader u_loader (
        .clk        (clk),
        .reset      (reset),
        .downloading(downloading),
        .ioctl_req  (ioctl_req),
        .ioctl_addr (ioctl_addr),
        .ioctl_data (ioctl_data),
        .ioctl_ack  (ioctl_ack),
        .prog_req   (prog_req),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .prog_mask  (prog_mask),
        .prog_ack   (prog_ack),
        .game_id    (game_id),
        .dec_flags  (dec_flags),
        .dwnld_busy (dwnld_busy)
    );

endmodule

// ==== tb.f ====
+incdir+design
design/sdram_pkg.sv
design/client_mapper.sv
design/bank_slot_arbiter.sv
design/sdram_bank_ctrl.sv
design/rom_loader.sv
design/sdram_subsys_top.sv
verif/sdram_properties.sv
verif/tb_sdram_subsys.sv

// ==== verif/sdram_properties.sv ====
// Handshake properties of the SDRAM front end
// Bound to the top level, covers client and download handshakes
`timescale 1ns/100ps
`include "sdram_defs.svh"

module sdram_properties
    import sdram_pkg::*;
(
    input logic                      clk,
    input logic                      reset,
    input logic                      lvbl,
    input logic [8:0]                vrender,
    input logic                      downloading,
    input logic [`NCLIENTS-1:0]      cli_req,
    input logic [`NCLIENTS-1:0]      cli_ack,
    input logic [`NBANKS-1:0][1:0]   slot_req,
    input logic                      ioctl_req,
    input logic                      ioctl_ack
);

    logic blanking;

    assign blanking = !lvbl || (vrender == 9'd0) || vrender[8];

    // A new ack always answers a raised req
    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        (cli_ack & ~$past(cli_ack) & ~cli_req) == '0)
        else $error("client ack rose without its req");

    ioctl_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(ioctl_ack) |-> ioctl_req)
        else $error("ioctl_ack rose without ioctl_req");

    ack_held: assert property (@(posedge clk) disable iff (reset)
        ($past(cli_ack & cli_req) & ~cli_ack) == '0)
        else $error("client ack dropped while req was still high");

    ioctl_ack_held: assert property (@(posedge clk) disable iff (reset)
        (ioctl_ack && ioctl_req) |=> ioctl_ack)
        else $error("ioctl_ack dropped while ioctl_req was still high");

    // No client gets through to a bank while the image is loaded
    no_req_in_download: assert property (@(posedge clk) disable iff (reset)
        $past(downloading) |-> (slot_req == '0))
        else $error("client request reached a bank while downloading");

    gfx_only_in_blank: assert property (@(posedge clk) disable iff (reset)
        (|cli_ack[`NCLIENTS-1:CLI_CHAR]) |-> blanking)
        else $error("graphics client acked outside blanking");

endmodule

bind sdram_subsys_top sdram_properties u_props (
    .clk        (clk),
    .reset      (reset),
    .lvbl       (lvbl),
    .vrender    (vrender),
    .downloading(downloading),
    .cli_req    (cli_req),
    .cli_ack    (cli_ack),
    .slot_req   (slot_req),
    .ioctl_req  (ioctl_req),
    .ioctl_ack  (ioctl_ack)
);

// ==== verif/tb_sdram_subsys.sv ====
// Testbench for the SDRAM memory front end
// Downloads an image, runs client traffic and compares read data
// against a shadow image kept by the testbench
`timescale 1ns/100ps
`include "sdram_defs.svh"

module tb_sdram_subsys
    import sdram_pkg::*;
();

    localparam int TIMEOUT   = 200;
    localparam int IMG_WORDS = 2**`MEM_AW;

    logic clk, reset, lvbl, downloading;
    logic [8:0] vrender;
    logic ioctl_req, ioctl_ack, dwnld_busy;
    logic [15:0] ioctl_addr;
    logic [7:0] ioctl_data;
    logic [1:0] game_id;
    logic [2:0] dec_flags;
    logic [`NCLIENTS-1:0] cli_req, cli_ack;
    client_cmd_t [`NCLIENTS-1:0] cli_cmd;
    word_t [`NCLIENTS-1:0] cli_rdata;

    word_t shadow [IMG_WORDS];          // Expected memory contents
    word_t exp_word [`NCLIENTS];
    logic [`NCLIENTS-1:0] exp_rd;       // Open request is a read
    logic [`NCLIENTS-1:0] ack_seen;
    logic [8:0] last_addr [`NCLIENTS];
    logic [8:0] rnd_addr [`NCLIENTS];
    int reads_checked;

    sdram_subsys_top UUT (
        .clk        (clk),
        .reset      (reset),
        .lvbl       (lvbl),
        .vrender    (vrender),
        .downloading(downloading),
        .ioctl_req  (ioctl_req),
        .ioctl_addr (ioctl_addr),
        .ioctl_data (ioctl_data),
        .ioctl_ack  (ioctl_ack),
        .dwnld_busy (dwnld_busy),
        .game_id    (game_id),
        .dec_flags  (dec_flags),
        .cli_req    (cli_req),
        .cli_cmd    (cli_cmd),
        .cli_ack    (cli_ack),
        .cli_rdata  (cli_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Client c sits in bank c/2, slot 1 in the upper half of the bank
    function automatic int shadow_index(int c, logic [8:0] a);
        return (c / 2) * (2**`BANK_AW) + int'(a) + (c % 2) * `SLOT1_OFFSET;
    endfunction

    function automatic word_t expected_word(int c, logic [8:0] a);
        return shadow[shadow_index(c, a)];
    endfunction

    function automatic word_t pattern_word(word_t seed, int w);
        return 16'(w * 40503) ^ seed;   // Odd multiplier, every address bit counts
    endfunction

    task automatic stop_run(string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "%s", why);
    endtask

    task automatic wait_cli_ack(int c, logic level);
        int n;
        logic done;
        n = 0;
        done = 1'b0;
        while (!done && n < TIMEOUT) begin
            @(negedge clk);
            done = (cli_ack[c] === level);
            n++;
        end
        if (!done) stop_run($sformatf("Timeout: cli_ack[%0d] never went to %0b", c, level));
    endtask

    task automatic wait_ioctl_ack(logic level);
        int n;
        logic done;
        n = 0;
        done = 1'b0;
        while (!done && n < TIMEOUT) begin
            @(negedge clk);
            done = (ioctl_ack === level);
            n++;
        end
        if (!done) stop_run($sformatf("Timeout: ioctl_ack never went to %0b", level));
    endtask

    task automatic issue(int c, logic [8:0] a, logic we, word_t wdata, logic [1:0] wmask);
        client_cmd_t cmd;
        int idx;
        cmd.addr  = a;
        cmd.we    = we;
        cmd.wdata = wdata;
        cmd.wmask = wmask;
        idx = shadow_index(c, a);
        @(posedge clk);
        if (we) begin
            if (!wmask[0]) shadow[idx][7:0] = wdata[7:0];     // Low mask bit enables
            if (!wmask[1]) shadow[idx][15:8] = wdata[15:8];
            exp_rd[c] = 1'b0;
        end else begin
            exp_word[c]  = expected_word(c, a);
            exp_rd[c]    = 1'b1;
            last_addr[c] = a;
        end
        cli_cmd[c] <= cmd;
        cli_req[c] <= 1'b1;
    endtask

    task automatic release_req(int c);
        @(posedge clk);
        cli_req[c] <= 1'b0;
        wait_cli_ack(c, 1'b0);
    endtask

    task automatic access(int c, logic [8:0] a, logic we, word_t wdata, logic [1:0] wmask);
        issue(c, a, we, wdata, wmask);
        wait_cli_ack(c, 1'b1);
        release_req(c);
    endtask

    task automatic read_word(int c, logic [8:0] a);
        access(c, a, 1'b0, '0, 2'b11);
    endtask

    task automatic send_byte(logic [15:0] addr, logic [7:0] data);
        @(posedge clk);
        ioctl_addr <= addr;
        ioctl_data <= data;
        ioctl_req  <= 1'b1;
        wait_ioctl_ack(1'b1);
        @(posedge clk);
        ioctl_req <= 1'b0;
        wait_ioctl_ack(1'b0);
    endtask

    task automatic download_image(word_t seed, logic [7:0] flags, logic [7:0] gid,
                                  int held_cli);
        word_t w_val;
        logic [7:0] hb;
        client_cmd_t cmd;
        int n;
        @(posedge clk);
        downloading <= 1'b1;
        @(negedge clk);
        assert (dwnld_busy === 1'b1)
            else stop_run("dwnld_busy did not rise with downloading");
        if (held_cli >= 0) begin
            cmd.addr  = last_addr[held_cli];
            cmd.we    = 1'b0;
            cmd.wdata = '0;
            cmd.wmask = 2'b11;
            @(posedge clk);
            cli_cmd[held_cli] <= cmd;   // Waits until the download is over
            cli_req[held_cli] <= 1'b1;
        end
        for (int i = 0; i < `HEADER_LEN; i++) begin
            hb = (i == 0) ? flags : (i == 1) ? gid : 8'($urandom);
            send_byte(16'(i), hb);
        end
        for (int w = 0; w < IMG_WORDS; w++) begin
            w_val = pattern_word(seed, w);
            send_byte(16'(`HEADER_LEN + 2 * w), w_val[7:0]);       // Low byte first
            send_byte(16'(`HEADER_LEN + 2 * w + 1), w_val[15:8]);
            shadow[w] = w_val;
        end
        @(posedge clk);
        downloading <= 1'b0;
        n = 0;
        while (dwnld_busy !== 1'b0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (dwnld_busy !== 1'b0) stop_run("Timeout: dwnld_busy stayed high after download");
        assert (dec_flags === flags[2:0]) else stop_run($sformatf(
            "CHECK FAILED at %0t: dec_flags = %0d, expected %0d", $time, dec_flags, flags[2:0]));
        assert (game_id === gid[1:0]) else stop_run($sformatf(
            "CHECK FAILED at %0t: game_id = %0d, expected %0d", $time, game_id, gid[1:0]));
        if (held_cli >= 0) begin
            exp_word[held_cli] = expected_word(held_cli, last_addr[held_cli]);
            exp_rd[held_cli]   = 1'b1;
            wait_cli_ack(held_cli, 1'b1);
            release_req(held_cli);
        end
    endtask

    // Read data check on every rising client ack
    always @(negedge clk) begin
        if (reset) begin
            ack_seen = '0;
        end else begin
            for (int c = 0; c < `NCLIENTS; c++) begin
                if (cli_ack[c] && !ack_seen[c] && exp_rd[c]) begin
                    assert (cli_rdata[c] === exp_word[c]) else begin
                        stop_run($sformatf("CHECK FAILED at %0t: cli_rdata[%0d] = %h, expected %h",
                                           $time, c, cli_rdata[c], exp_word[c]));
                    end
                    reads_checked++;
                end
            end
            ack_seen = cli_ack;
        end
    end

    initial begin
        logic [8:0] a;
        logic [1:0] mask;
        void'($urandom(32'hb6f8));
        reset = 1'b1;
        lvbl = 1'b0;            // Blanking, graphics allowed
        vrender = '0;
        downloading = 1'b0;
        ioctl_req = 1'b0;
        ioctl_addr = '0;
        ioctl_data = '0;
        cli_req = '0;
        cli_cmd = '0;
        exp_rd = '0;
        reads_checked = 0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        download_image(16'h5a3c, 8'd5, 8'd2, -1);

        // Random reads from every client, then a repeat of each last address
        for (int n = 0; n < 8; n++) begin
            for (int c = 0; c < `NCLIENTS; c++) read_word(c, 9'($urandom));
        end
        for (int c = 0; c < `NCLIENTS; c++) read_word(c, last_addr[c]);

        // Masked writes from the main RAM client
        for (int m = 0; m < 3; m++) begin
            mask = (m == 0) ? 2'b00 : (m == 1) ? 2'b01 : 2'b10;
            a = 9'($urandom);
            read_word(CLI_MAIN_RAM, a);
            access(CLI_MAIN_RAM, a, 1'b1, 16'($urandom), mask);
            read_word(CLI_MAIN_RAM, a);
            read_word(CLI_MAIN_RAM, a);     // Hit in the last word
            a = a ^ 9'h155;
            access(CLI_MAIN_RAM, a, 1'b1, 16'($urandom), mask);
            read_word(CLI_MAIN_RAM, a);
        end

        // Graphics held off during active display
        @(posedge clk);
        lvbl    <= 1'b1;
        vrender <= 9'd100;
        issue(CLI_SCROLL, 9'($urandom), 1'b0, '0, 2'b11);
        for (int i = 0; i < 50; i++) begin
            @(negedge clk);
            assert (cli_ack[CLI_SCROLL] === 1'b0)
                else stop_run("Graphics client was acked during active display");
        end
        @(posedge clk);
        vrender <= 9'd256;
        wait_cli_ack(CLI_SCROLL, 1'b1);
        release_req(CLI_SCROLL);

        // All clients at once
        for (int r = 0; r < 10; r++) begin
            for (int k = 0; k < `NCLIENTS; k++) rnd_addr[k] = 9'($urandom);
            fork
                read_word(0, rnd_addr[0]);
                read_word(1, rnd_addr[1]);
                read_word(2, rnd_addr[2]);
                read_word(3, rnd_addr[3]);
                read_word(4, rnd_addr[4]);
                read_word(5, rnd_addr[5]);
                read_word(6, rnd_addr[6]);
                read_word(7, rnd_addr[7]);
            join
        end

        // New image, the cached words must not survive
        download_image(16'hc3a5, 8'd3, 8'd1, CLI_SOUND);  // Sound read waits across it
        for (int c = 0; c < `NCLIENTS; c++) read_word(c, last_addr[c]);
        for (int n = 0; n < 4; n++) begin
            for (int c = 0; c < `NCLIENTS; c++) read_word(c, 9'($urandom));
        end

        if (reads_checked > 0) begin
            $display("No errors");
            $finish;
        end else begin
            stop_run("No read data was checked");
        end
    end

endmodule
